//--- build.f
+incdir+include
logic/ctrl_proto_pkg.sv
logic/ctrl_core_pkg.sv
logic/packet_decoder.sv
logic/test_checker.sv
logic/report_writer.sv
logic/test_controller.sv
test/tb_test_controller.sv

//--- logic/ctrl_core_pkg.sv
// Internal structs, state enums and report sizing of the controller
package ctrl_core_pkg;

    import ctrl_proto_pkg::*;

    // ================================================
    // Reply reports
    // ================================================

    // Header plus up to three bytes
    localparam int REPORT_BYTES = 4;

    typedef logic [1:0] rep_idx_t;

    // Entry 0 is the header, count is the number of bytes after it
    typedef struct packed {
        rep_idx_t                   count;
        byte_t [REPORT_BYTES-1:0]   bytes;
    } report_t;

    // ================================================
    // Decoder output
    // ================================================

    // Data is the whole header byte for headers, the raw byte otherwise
    typedef struct packed {
        logic  is_header;
        cmd_t  cmd;
        byte_t data;
    } dec_item_t;

    // ================================================
    // State machines
    // ================================================

    typedef enum logic {
        DEC_HEADER,
        DEC_PAYLOAD
    } dec_state_e;

    typedef enum logic {
        CHK_RUN,
        CHK_STOPPED
    } chk_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_SEND
    } wr_state_e;

endpackage

//--- logic/ctrl_proto_pkg.sv
// Byte stream protocol types, command codes, test numbers and error codes
package ctrl_proto_pkg;

    // ================================================
    // Basic widths
    // ================================================

    // One byte as it travels through the FIFOs
    typedef logic [7:0] byte_t;

    // Payload length field of a header
    typedef logic [5:0] len_t;

    // ================================================
    // Packet header
    // ================================================

    typedef enum logic [1:0] {
        CMD_START   = 2'd0,
        CMD_DATA    = 2'd1,
        CMD_STOP    = 2'd2,
        CMD_STOPPED = 2'd3
    } cmd_t;

    // Command in the top two bits, payload length below
    typedef struct packed {
        cmd_t cmd;
        len_t len;
    } packet_header_t;

    // ================================================
    // Test numbers carried by START
    // ================================================

    localparam byte_t TEST_RECEIVE      = 8'h01;
    localparam byte_t TEST_RECEIVE_SEND = 8'h02;

    // ================================================
    // Error codes of the STOPPED reply
    // ================================================

    localparam byte_t ERR_NONE          = 8'h00;
    localparam byte_t ERR_INVALID_CMD   = 8'h01;
    localparam byte_t ERR_START_PAYLOAD = 8'h02;
    localparam byte_t ERR_STOP_PAYLOAD  = 8'h03;
    localparam byte_t ERR_TEST_NUM      = 8'h04;
    localparam byte_t ERR_TEST_DATA     = 8'h05;

endpackage

//--- logic/packet_decoder.sv
// Packet decoder module: input FIFO reader and header/payload splitter
`timescale 1ns/100ps

module packet_decoder
    import ctrl_proto_pkg::*, ctrl_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      in_empty_i,
    input  byte_t     in_data_i,
    output logic      in_rd_o,
    output dec_item_t item_o,
    output logic      item_valid_o,
    input  logic      item_ready_i
);

    dec_state_e     state_q;
    cmd_t           cmd_q;
    len_t           remain_q;
    logic           capture_q;
    logic           hold_q;
    dec_item_t      item_q;
    dec_item_t      item_d;
    packet_header_t hdr;
    logic           item_take;

    assign hdr       = packet_header_t'(in_data_i);
    assign item_take = hold_q & item_ready_i;

    assign item_o       = item_q;
    assign item_valid_o = hold_q;

    // Tag the returning byte with the command in force
    always_comb begin
        item_d.data = in_data_i;
        if (state_q == DEC_HEADER) begin
            item_d.is_header = 1'b1;
            item_d.cmd       = hdr.cmd;
        end else begin
            item_d.is_header = 1'b0;
            item_d.cmd       = cmd_q;
        end
    end

    // ================================================
    // Read request, capture and packet tracking
    // ================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q   <= DEC_HEADER;
            cmd_q     <= CMD_START;
            remain_q  <= '0;
            capture_q <= 1'b0;
            hold_q    <= 1'b0;
            in_rd_o   <= 1'b0;
        end else begin
            // Byte requested now shows up on the bus next cycle
            capture_q <= in_rd_o;
            // Single request in flight, and only into a free hold register
            in_rd_o   <= ~in_empty_i & ~in_rd_o & ~capture_q & (~hold_q | item_take);

            if (capture_q) begin
                hold_q <= 1'b1;
                if (state_q == DEC_HEADER) begin
                    if (hdr.len != '0) begin
                        state_q  <= DEC_PAYLOAD;
                        cmd_q    <= hdr.cmd;
                        remain_q <= hdr.len;
                    end
                end else begin
                    remain_q <= remain_q - len_t'(1);
                    if (remain_q == len_t'(1)) begin
                        state_q <= DEC_HEADER;
                    end
                end
            end else if (item_take) begin
                hold_q <= 1'b0;
            end
        end
    end

    // Hold register contents
    always_ff @(posedge clk) begin
        if (capture_q) begin
            item_q <= item_d;
        end
    end

    // FIFO must still be non-empty when the registered request comes out
    a_rd_not_empty: assert property (@(posedge clk) disable iff (reset_i)
        $rose(in_rd_o) |-> !in_empty_i);

endmodule

//--- logic/report_writer.sv
// Report writer module: output FIFO writer and final test status flags
`timescale 1ns/100ps

module report_writer
    import ctrl_proto_pkg::*, ctrl_core_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  report_t report_i,
    input  logic    report_valid_i,
    output logic    writer_busy_o,
    input  logic    out_full_i,
    input  logic    out_afull_i,
    output logic    out_wr_o,
    output byte_t   out_data_o,
    output logic    test_ok_o,
    output logic    test_fail_o
);

    wr_state_e      state_q;
    rep_idx_t       idx_q;
    report_t        rep_q;
    packet_header_t rep_hdr;
    logic           take;
    logic           send;
    logic           last;

    assign rep_hdr       = packet_header_t'(rep_q.bytes[0]);
    assign take          = (state_q == WR_IDLE) & report_valid_i;
    // One byte per cycle unless the FIFO pushes back
    assign send          = (state_q == WR_SEND) & ~out_full_i & ~out_afull_i;
    assign last          = idx_q == rep_q.count;
    assign writer_busy_o = state_q == WR_SEND;

    // ================================================
    // Byte sequencing and status flags
    // ================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q     <= WR_IDLE;
            idx_q       <= '0;
            out_wr_o    <= 1'b0;
            test_ok_o   <= 1'b0;
            test_fail_o <= 1'b0;
        end else begin
            out_wr_o <= send;
            if (take) begin
                state_q <= WR_SEND;
                idx_q   <= '0;
            end else if (send) begin
                idx_q <= idx_q + rep_idx_t'(1);
                if (last) begin
                    state_q <= WR_IDLE;
                    // STOPPED reply closes the test
                    if (rep_hdr.cmd == CMD_STOPPED) begin
                        test_ok_o   <= test_ok_o | (rep_q.bytes[1] == ERR_NONE);
                        test_fail_o <= test_fail_o | (rep_q.bytes[1] != ERR_NONE);
                    end
                end
            end
        end
    end

    // Report buffer and output byte
    always_ff @(posedge clk) begin
        if (take) begin
            rep_q <= report_i;
        end
        if (send) begin
            out_data_o <= rep_q.bytes[idx_q];
        end
    end

    // New report only while no other report is being written
    a_report_when_idle: assert property (@(posedge clk) disable iff (reset_i)
        report_valid_i |-> !writer_busy_o);

endmodule

//--- logic/test_checker.sv
// Test checker module: test state, sequence check, echo and STOPPED reply decisions
`timescale 1ns/100ps

module test_checker
    import ctrl_proto_pkg::*, ctrl_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  dec_item_t item_i,
    input  logic      item_valid_i,
    output logic      item_ready_o,
    input  logic      writer_busy_i,
    output report_t   report_o,
    output logic      report_valid_o
);

    chk_state_e     state_q;
    byte_t          test_num_q;
    byte_t          expect_q;
    packet_header_t hdr;
    logic           accept;
    logic           data_ok;
    logic           known_test;
    logic           stop;
    logic           need_rep;
    report_t        rep;

    // Reply header byte from command and byte count
    function automatic byte_t reply_hdr(cmd_t cmd, rep_idx_t count);
        packet_header_t h;
        h.cmd = cmd;
        h.len = len_t'(count);
        return byte_t'(h);
    endfunction

    assign hdr          = packet_header_t'(item_i.data);
    assign item_ready_o = (state_q == CHK_RUN) & ~writer_busy_i;
    assign accept       = item_valid_i & item_ready_o;
    assign data_ok      = item_i.data == expect_q;
    assign known_test   = (item_i.data == TEST_RECEIVE) | (item_i.data == TEST_RECEIVE_SEND);

    // ================================================
    // Reply selection
    // ================================================
    always_comb begin
        rep      = '0;
        stop     = 1'b0;
        need_rep = 1'b0;
        if (item_i.is_header) begin
            case (hdr.cmd)
                CMD_START: begin
                    if (hdr.len != len_t'(1)) begin
                        stop          = 1'b1;
                        rep.count     = 2'd1;
                        rep.bytes[1]  = ERR_START_PAYLOAD;
                    end
                end
                CMD_STOP: begin
                    stop          = 1'b1;
                    rep.count     = 2'd1;
                    rep.bytes[1]  = (hdr.len == '0) ? ERR_NONE : ERR_STOP_PAYLOAD;
                end
                CMD_STOPPED: begin
                    stop          = 1'b1;
                    rep.count     = 2'd1;
                    rep.bytes[1]  = ERR_INVALID_CMD;
                end
                default: begin
                    // DATA header just opens its payload
                end
            endcase
        end else begin
            case (item_i.cmd)
                CMD_START: begin
                    if (!known_test) begin
                        stop          = 1'b1;
                        rep.count     = 2'd2;
                        rep.bytes[1]  = ERR_TEST_NUM;
                        rep.bytes[2]  = item_i.data;
                    end
                end
                CMD_DATA: begin
                    if (!data_ok) begin
                        stop          = 1'b1;
                        rep.count     = 2'd3;
                        rep.bytes[1]  = ERR_TEST_DATA;
                        rep.bytes[2]  = item_i.data;
                        rep.bytes[3]  = expect_q;
                    end else if (test_num_q == TEST_RECEIVE_SEND) begin
                        // Loopback of the good byte
                        need_rep      = 1'b1;
                        rep.count     = 2'd1;
                        rep.bytes[0]  = reply_hdr(CMD_DATA, 2'd1);
                        rep.bytes[1]  = item_i.data;
                    end
                end
                default: begin
                    // STOP and STOPPED never carry payload past the checker
                end
            endcase
        end
        if (stop) begin
            need_rep     = 1'b1;
            rep.bytes[0] = reply_hdr(CMD_STOPPED, rep.count);
        end
    end

    assign report_o       = rep;
    assign report_valid_o = accept & need_rep;

    // ================================================
    // Test state
    // ================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q    <= CHK_RUN;
            test_num_q <= TEST_RECEIVE;
            expect_q   <= '0;
        end else if (accept) begin
            if (stop) begin
                state_q <= CHK_STOPPED;
            end
            if (item_i.is_header) begin
                if (hdr.cmd == CMD_START && hdr.len == len_t'(1)) begin
                    expect_q <= '0;
                end
            end else if (item_i.cmd == CMD_START) begin
                test_num_q <= item_i.data;
            end else if (item_i.cmd == CMD_DATA && data_ok) begin
                expect_q <= expect_q + 8'd1;
            end
        end
    end

    // Writer takes every report on the next edge
    a_report_taken: assert property (@(posedge clk) disable iff (reset_i)
        report_valid_o |=> writer_busy_i);

endmodule

//--- logic/test_controller.sv
// Test controller top level: decoder, checker and report writer
`timescale 1ns/100ps

module test_controller
    import ctrl_proto_pkg::*, ctrl_core_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    // Input FIFO
    input  logic  in_empty_i,
    input  byte_t in_data_i,
    output logic  in_rd_o,
    // Output FIFO
    input  logic  out_full_i,
    input  logic  out_afull_i,
    output logic  out_wr_o,
    output byte_t out_data_o,
    // Test status
    output logic  test_ok_o,
    output logic  test_fail_o
);

    dec_item_t item;
    logic      item_valid;
    logic      item_ready;
    report_t   report;
    logic      report_valid;
    logic      writer_busy;

    packet_decoder i_packet_decoder (
        .clk          (clk),
        .reset_i      (reset_i),
        .in_empty_i   (in_empty_i),
        .in_data_i    (in_data_i),
        .in_rd_o      (in_rd_o),
        .item_o       (item),
        .item_valid_o (item_valid),
        .item_ready_i (item_ready)
    );

    test_checker i_test_checker (
        .clk            (clk),
        .reset_i        (reset_i),
        .item_i         (item),
        .item_valid_i   (item_valid),
        .item_ready_o   (item_ready),
        .writer_busy_i  (writer_busy),
        .report_o       (report),
        .report_valid_o (report_valid)
    );

    report_writer i_report_writer (
        .clk            (clk),
        .reset_i        (reset_i),
        .report_i       (report),
        .report_valid_i (report_valid),
        .writer_busy_o  (writer_busy),
        .out_full_i     (out_full_i),
        .out_afull_i    (out_afull_i),
        .out_wr_o       (out_wr_o),
        .out_data_o     (out_data_o),
        .test_ok_o      (test_ok_o),
        .test_fail_o    (test_fail_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the test controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_test_controller \
    -f build.f \
    -o sim_tb_test_controller

./obj_dir/sim_tb_test_controller | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- include/tb_model.svh
// Reference model, LCG function and value compare task of the controller testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ==================================================
// Random numbers
// ==================================================

// Next LCG step, upper half only since the low bits cycle fast
function automatic int lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'({16'h0000, lcg_state[31:16]});
endfunction

// ==================================================
// Checks
// ==================================================

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: %s is %h, expected %h", name, got, exp);
    end
endtask

// ==================================================
// Reference model
// ==================================================

// STOPPED header, error code and up to two diagnostic bytes
task automatic push_stopped_reply(input byte_t code, input int n_extra,
                                  input byte_t x1, input byte_t x2);
    exp_q.push_back(8'hC0 | byte_t'(n_extra + 1));
    exp_q.push_back(code);
    if (n_extra > 0) begin
        exp_q.push_back(x1);
    end
    if (n_extra > 1) begin
        exp_q.push_back(x2);
    end
    exp_ok   = (code == ERR_NONE);
    exp_fail = (code != ERR_NONE);
endtask

// Walks sess_q packet by packet and fills exp_q, the flags and exp_used
task automatic run_model();
    int    i;
    int    k;
    int    len;
    cmd_t  cmd;
    byte_t b;
    byte_t test_num;
    byte_t expect_b;
    logic  stopped;

    exp_q.delete();
    exp_ok   = 1'b0;
    exp_fail = 1'b0;
    test_num = TEST_RECEIVE;
    expect_b = 8'h00;
    stopped  = 1'b0;
    i        = 0;
    while (!stopped && i < sess_q.size()) begin
        cmd = cmd_t'(sess_q[i][7:6]);
        len = int'(sess_q[i][5:0]);
        i++;
        if (cmd == CMD_START && len != 1) begin
            push_stopped_reply(ERR_START_PAYLOAD, 0, 8'h00, 8'h00);
            stopped = 1'b1;
        end else if (cmd == CMD_START) begin
            expect_b = 8'h00;
        end else if (cmd == CMD_STOP) begin
            push_stopped_reply((len == 0) ? ERR_NONE : ERR_STOP_PAYLOAD, 0, 8'h00, 8'h00);
            stopped = 1'b1;
        end else if (cmd == CMD_STOPPED) begin
            push_stopped_reply(ERR_INVALID_CMD, 0, 8'h00, 8'h00);
            stopped = 1'b1;
        end
        k = 0;
        while (!stopped && k < len && i < sess_q.size()) begin
            b = sess_q[i];
            i++;
            k++;
            if (cmd == CMD_START) begin
                if (b == TEST_RECEIVE || b == TEST_RECEIVE_SEND) begin
                    test_num = b;
                end else begin
                    push_stopped_reply(ERR_TEST_NUM, 1, b, 8'h00);
                    stopped = 1'b1;
                end
            end else if (b != expect_b) begin
                push_stopped_reply(ERR_TEST_DATA, 2, b, expect_b);
                stopped = 1'b1;
            end else begin
                if (test_num == TEST_RECEIVE_SEND) begin
                    exp_q.push_back(8'h41);
                    exp_q.push_back(b);
                end
                expect_b = expect_b + 8'd1;
            end
        end
    end
    // Decoder keeps reading into its hold register once more after the stop
    exp_used = i + ((i < sess_q.size()) ? 1 : 0);
endtask

`endif

//--- test/tb_test_controller.sv
// Testbench of the test controller: clock, reset, FIFO models, random sessions and watchdog
`timescale 1ns/100ps

module tb_test_controller
    import ctrl_proto_pkg::*;
();

    localparam int          NUM_SESSIONS = 14;
    localparam int          QUIET_CYCLES = 20;
    localparam logic [31:0] SEED         = 32'h5ba1_2d1e;

    logic  clk         = 1'b0;
    logic  reset_i     = 1'b1;
    logic  in_empty_i  = 1'b1;
    byte_t in_data_i   = 8'h00;
    logic  in_rd_o;
    logic  out_full_i  = 1'b0;
    logic  out_afull_i = 1'b0;
    logic  out_wr_o;
    byte_t out_data_o;
    logic  test_ok_o;
    logic  test_fail_o;

    logic [31:0] lcg_state      = SEED;
    logic        bp_on          = 1'b0;
    logic        bp_last        = 1'b0;
    logic        sessions_built = 1'b0;
    int          limit_cycles   = 0;
    int          rd_count       = 0;
    int          value_errors   = 0;
    int          proto_errors   = 0;

    // Stimulus of all sessions back to back
    byte_t all_bytes[$];
    int    sess_start[$];
    int    sess_len[$];
    // Current session, FIFO contents and results
    byte_t sess_q[$];
    byte_t in_fifo[$];
    byte_t out_q[$];
    byte_t exp_q[$];
    logic  exp_ok;
    logic  exp_fail;
    int    exp_used;

    `include "tb_model.svh"

    test_controller i_test_controller (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_empty_i  (in_empty_i),
        .in_data_i   (in_data_i),
        .in_rd_o     (in_rd_o),
        .out_full_i  (out_full_i),
        .out_afull_i (out_afull_i),
        .out_wr_o    (out_wr_o),
        .out_data_o  (out_data_o),
        .test_ok_o   (test_ok_o),
        .test_fail_o (test_fail_o)
    );

    always #5 clk = ~clk;

    function automatic int rand_below(input int n);
        return lcg_next() % n;
    endfunction

    // ==================================================
    // Session generation
    // ==================================================

    // Kinds: 0 RECEIVE, 1 RECEIVE_SEND, 2 bad data, 3 bad START length,
    // 4 bad STOP length, 5 STOPPED as input, 6 unknown test number
    task automatic build_sessions();
        int    s;
        int    p;
        int    j;
        int    kind;
        int    len;
        int    n_pkts;
        int    pick;
        byte_t seq;
        byte_t b;
        logic  corrupted;

        for (s = 0; s < NUM_SESSIONS; s++) begin
            kind = s % 7;
            sess_start.push_back(all_bytes.size());
            if (kind == 3) begin
                len = (rand_below(2) == 0) ? 0 : 2 + rand_below(4);
                all_bytes.push_back(byte_t'(len));
                for (j = 0; j < len; j++) begin
                    all_bytes.push_back(byte_t'(rand_below(256)));
                end
            end else begin
                all_bytes.push_back(8'h01);
                if (kind == 1) begin
                    all_bytes.push_back(TEST_RECEIVE_SEND);
                end else if (kind == 6) begin
                    pick = rand_below(3);
                    if (pick == 0) begin
                        all_bytes.push_back(8'h00);
                    end else if (pick == 1) begin
                        all_bytes.push_back(8'h03);
                    end else begin
                        all_bytes.push_back(byte_t'(3 + rand_below(253)));
                    end
                end else begin
                    all_bytes.push_back(TEST_RECEIVE);
                end
            end
            // DATA packets counting up from zero
            n_pkts    = 1 + rand_below(3);
            seq       = 8'h00;
            corrupted = 1'b0;
            for (p = 0; p < n_pkts; p++) begin
                len = 1 + rand_below(16);
                all_bytes.push_back(8'h40 | byte_t'(len));
                for (j = 0; j < len; j++) begin
                    b   = seq;
                    seq = seq + 8'd1;
                    if (kind == 2 && !corrupted &&
                        (rand_below(6) == 0 || (p == n_pkts - 1 && j == len - 1))) begin
                        b         = b ^ byte_t'(1 + rand_below(255));
                        corrupted = 1'b1;
                    end
                    all_bytes.push_back(b);
                end
            end
            if (kind == 4) begin
                len = 1 + rand_below(3);
                all_bytes.push_back(8'h80 | byte_t'(len));
                for (j = 0; j < len; j++) begin
                    all_bytes.push_back(byte_t'(rand_below(256)));
                end
            end else if (kind == 5) begin
                all_bytes.push_back(8'hC0 | byte_t'(rand_below(4)));
            end else begin
                all_bytes.push_back(8'h80);
            end
            // Bytes after the end that must stay unread
            len = 1 + rand_below(3);
            for (j = 0; j < len; j++) begin
                all_bytes.push_back(byte_t'(rand_below(256)));
            end
            sess_len.push_back(all_bytes.size() - sess_start[s]);
        end
    endtask

    // ==================================================
    // FIFO models
    // ==================================================

    // Input FIFO with one cycle read latency
    always @(posedge clk) begin
        if (in_rd_o) begin
            in_data_i <= in_fifo.pop_front();
            rd_count  <= rd_count + 1;
        end
        in_empty_i <= (in_fifo.size() == 0);
    end

    // Output FIFO collector and random back-pressure
    always @(posedge clk) begin
        if (out_wr_o) begin
            out_q.push_back(out_data_o);
            if (bp_last) begin
                proto_errors <= proto_errors + 1;
                $display("Output FIFO was written one cycle after it signalled full");
            end
        end
        bp_last <= out_full_i | out_afull_i;
        if (bp_on) begin
            out_full_i  <= (rand_below(8) == 0);
            out_afull_i <= (rand_below(4) == 0);
        end else begin
            out_full_i  <= 1'b0;
            out_afull_i <= 1'b0;
        end
    end

    // ==================================================
    // Sessions and checks
    // ==================================================
    initial begin
        int s;
        int k;
        int rd_base;
        int out_base;

        build_sessions();
        limit_cycles   = all_bytes.size() * 40 + NUM_SESSIONS * 200;
        sessions_built = 1'b1;
        for (s = 0; s < NUM_SESSIONS; s++) begin
            @(posedge clk);
            reset_i <= 1'b1;
            bp_on   <= (s >= NUM_SESSIONS / 2);
            @(posedge clk);
            sess_q.delete();
            for (k = 0; k < sess_len[s]; k++) begin
                sess_q.push_back(all_bytes[sess_start[s] + k]);
            end
            in_fifo = sess_q;
            run_model();
            rd_base  = rd_count;
            out_base = out_q.size();
            repeat (4) @(posedge clk);
            reset_i <= 1'b0;
            // Status flags mark the STOPPED reply as fully written
            while (!(test_ok_o || test_fail_o)) begin
                @(posedge clk);
            end
            repeat (QUIET_CYCLES) @(posedge clk);
            compare_value("out byte count", out_q.size() - out_base, exp_q.size());
            for (k = 0; k < exp_q.size() && out_base + k < out_q.size(); k++) begin
                compare_value($sformatf("out_data_o[%0d]", k),
                              32'(out_q[out_base + k]), 32'(exp_q[k]));
            end
            compare_value("test_ok_o", 32'(test_ok_o), 32'(exp_ok));
            compare_value("test_fail_o", 32'(test_fail_o), 32'(exp_fail));
            compare_value("in_rd_o count", rd_count - rd_base, exp_used);
        end
        $display("Summary: %0d sessions, %0d value errors, %0d protocol errors",
                 NUM_SESSIONS, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the generated stimulus
    initial begin
        wait (sessions_built);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the sessions did not finish within %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
